/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_scoreboard \
	-f tb.f -o tb_scoreboard_sim &&
./obj_dir/tb_scoreboard_sim ||
{ echo "simulation run did not pass"; exit 1; }

/* sim/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int unsigned lcg_state = 32'd81236; // fixed seed

// 32-bit lcg returning the upper half
function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state >> 16; // low bits repeat too quickly
endfunction

// uniform-ish value in lo..hi
function automatic int rand_range(int lo, int hi);
	int unsigned span;
	span = unsigned'(hi - lo + 1);
	return lo + int'(lcg_next() % span);
endfunction

// colour that the frame store should receive at (px, py)
function automatic colour_t expected_pixel(int px, int py, int d0, int d1, int d2, int d3);
	int dx [4];
	int dv [4];
	int lx;
	int ly;
	logic [23:0] drow;
	glyph_row_t lrow;
	dx = '{DIGIT_X0, DIGIT_X1, DIGIT_X2, DIGIT_X3}; // score tens first
	dv = '{d0, d1, d2, d3};
	for (int i = 0; i < 4; i++)
	begin
		if ((px >= dx[i]) && (px < dx[i] + DIGIT_W) && (py >= DIGIT_Y) && (py < DIGIT_Y + DIGIT_H))
		begin
			lx = px - dx[i];
			ly = py - DIGIT_Y;
			if (dv[i] > 9)
				return BLACK; // out-of-range digit shows nothing
			drow = DIGIT_ROWS[dv[i]][ly / 4]; // 4 rows per band
			return drow[DIGIT_W - 1 - lx] ? DIGIT_COLOUR : BLACK;
		end
	end
	if ((py >= LABEL_Y) && (py < LABEL_Y + LABEL_H))
	begin
		ly = py - LABEL_Y;
		if ((px >= SCORE_LBL_X) && (px < SCORE_LBL_X + LABEL_W))
		begin
			lx = px - SCORE_LBL_X;
			lrow = SCORE_ROWS[ly];
			return lrow[LABEL_W - 1 - lx] ? SCORE_COLOUR : BLACK;
		end
		if ((px >= TIMER_LBL_X) && (px < TIMER_LBL_X + LABEL_W))
		begin
			lx = px - TIMER_LBL_X;
			lrow = TIMER_ROWS[ly];
			return lrow[LABEL_W - 1 - lx] ? TIMER_COLOUR : BLACK;
		end
	end
	return BLACK; // background
endfunction

`endif

/* sim/tb_scoreboard.sv */
`timescale 1ns/10ps

module tb_scoreboard;
	import screen_pkg::*;
	import glyph_pkg::*;

	localparam int FRAME_PERIOD = 20_000; // short refresh period
	localparam int GAP_CYCLES = FRAME_PERIOD - PIXELS_PER_FRAME; // plot idle after a frame
	localparam int NUM_FRAMES = 4;
	localparam int WAIT_LIMIT = FRAME_PERIOD + 10; // no wait spans more than one period

	logic iClock = 1'b0;
	logic resetn;
	digit_t score_tens;
	digit_t score_ones;
	digit_t timer_tens;
	digit_t timer_ones;
	x_t x;
	y_t y;
	colour_t colour;
	logic plot;

	int frame_dig [4]; // digits the frame under check must show
	int next_dig [4]; // digits currently on the inputs
	int digit_lit; // per-frame colour counts
	int score_lit;
	int timer_lit;

	`include "tb_model.svh"

	scoreboard_renderer #(.FRAME_PERIOD(FRAME_PERIOD)) UUT
	(
		.iClock(iClock),
		.resetn(resetn),
		.score_tens(score_tens),
		.score_ones(score_ones),
		.timer_tens(timer_tens),
		.timer_ones(timer_ones),
		.x(x),
		.y(y),
		.colour(colour),
		.plot(plot)
	);

	always #20 iClock = ~iClock; // 40 ns period

	task automatic abort_run(string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic fail_value(string name, logic [31:0] expected, logic [31:0] actual);
		abort_run($sformatf("error at %0t: %s expected %0h got %0h", $time, name, expected,
			actual));
	endtask

	// put next_dig on the digit inputs
	task automatic apply_digits();
		score_tens = digit_t'(next_dig[0]);
		score_ones = digit_t'(next_dig[1]);
		timer_tens = digit_t'(next_dig[2]);
		timer_ones = digit_t'(next_dig[3]);
	endtask

	task automatic draw_digits(int lo, int hi);
		for (int i = 0; i < 4; i++)
			next_dig[i] = rand_range(lo, hi);
		apply_digits();
	endtask

	// step falling edges until plot is seen high and check the count against the frame timing
	task automatic wait_for_plot(int expected_wait);
		int waited;
		waited = 0;
		do
		begin
			@(negedge iClock);
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("timeout while waiting for plot to rise");
		end while (plot !== 1'b1);
		assert (waited == expected_wait)
		else abort_run($sformatf("plot rose after %0d cycles instead of %0d", waited,
			expected_wait));
	endtask

	// 19200 back-to-back plot cycles in raster order
	task automatic check_frame(int change_at, bit blank_frame);
		colour_t exp_colour;
		int px;
		int py;
		digit_lit = 0;
		score_lit = 0;
		timer_lit = 0;
		for (int idx = 0; idx < PIXELS_PER_FRAME; idx++)
		begin
			if (idx > 0)
				@(negedge iClock);
			px = idx % SCREEN_W;
			py = idx / SCREEN_W;
			if (idx == change_at)
			begin
				for (int i = 0; i < 4; i++)
					next_dig[i] = (frame_dig[i] + 1 + rand_range(0, 8)) % 10; // always differs
				apply_digits(); // must not reach this frame
			end
			assert (plot === 1'b1) else fail_value("plot", 1, plot);
			assert (x === x_t'(px)) else fail_value("x", px, x);
			assert (y === y_t'(py)) else fail_value("y", py, y);
			exp_colour = expected_pixel(px, py, frame_dig[0], frame_dig[1], frame_dig[2],
				frame_dig[3]);
			assert (colour === exp_colour) else fail_value("colour", exp_colour, colour);
			if (colour == DIGIT_COLOUR)
				digit_lit++;
			if (colour == SCORE_COLOUR)
				score_lit++;
			if (colour == TIMER_COLOUR)
				timer_lit++;
		end
		if (blank_frame)
		begin
			assert (digit_lit == 0) else abort_run("blank digits still lit some pixels");
			assert (score_lit > 0) else abort_run("score label missing in blank-digit frame");
			assert (timer_lit > 0) else abort_run("timer label missing in blank-digit frame");
		end
	endtask

	initial
	begin
		resetn = 1'b0;
		score_tens = '0;
		score_ones = '0;
		timer_tens = '0;
		timer_ones = '0;
		draw_digits(0, 9); // frame 0 digits latched by the first scan pixel
		frame_dig = next_dig;
		repeat (10)
		begin
			@(negedge iClock);
			assert (plot === 1'b0) else fail_value("plot", 0, plot);
		end
		resetn = 1'b1;
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			wait_for_plot((f == 0) ? 2 : GAP_CYCLES + 1); // pipeline fill then idle gap
			if (f == 1)
			begin
				// change lands above the digit boxes so every digit row sees it
				check_frame(rand_range(1000, DIGIT_Y * SCREEN_W - 1), 1'b0);
			end
			else
				check_frame(-1, f == NUM_FRAMES - 1);
			if (f == 0)
			begin
				draw_digits(0, 9); // set during the idle gap
				frame_dig = next_dig;
			end
			else if (f == 1)
				frame_dig = next_dig; // mid-frame values belong to the next frame
			else if (f == 2)
			begin
				draw_digits(10, 15); // all four boxes go dark
				frame_dig = next_dig;
			end
		end
		$display("test passed");
		$finish;
	end

endmodule

/* source/glyph_pkg.sv */
package glyph_pkg;

	typedef logic [2:0] colour_t; // {red, green, blue}
	typedef logic [3:0] digit_t; // 10..15 draw blank

	localparam int GLYPH_ROW_W = 50; // widest glyph is a label
	typedef logic [GLYPH_ROW_W-1:0] glyph_row_t; // column 0 sits in the msb

	localparam colour_t BLACK = 3'b000;
	localparam colour_t DIGIT_COLOUR = 3'b001; // blue
	localparam colour_t SCORE_COLOUR = 3'b010; // green
	localparam colour_t TIMER_COLOUR = 3'b100; // red

	// one band of a digit glyph, 4 px stroke, column 0 in bit 23
	localparam logic [23:0] SEG_O = 24'h000000; // nothing lit
	localparam logic [23:0] SEG_H = 24'h0FFFF0; // horizontal bar
	localparam logic [23:0] SEG_L = 24'hF00000; // left stroke
	localparam logic [23:0] SEG_R = 24'h00000F; // right stroke
	localparam logic [23:0] SEG_B = 24'hF0000F; // both strokes

	// band 0 top bar, 1-4 upper strokes, 5 middle bar, 6-9 lower strokes, 10 bottom bar
	localparam logic [23:0] DIGIT_ROWS [10][11] = '{
		'{SEG_H, SEG_B, SEG_B, SEG_B, SEG_B, SEG_O, SEG_B, SEG_B, SEG_B, SEG_B, SEG_H}, // 0
		'{SEG_O, SEG_R, SEG_R, SEG_R, SEG_R, SEG_O, SEG_R, SEG_R, SEG_R, SEG_R, SEG_O}, // 1
		'{SEG_H, SEG_R, SEG_R, SEG_R, SEG_R, SEG_H, SEG_L, SEG_L, SEG_L, SEG_L, SEG_H}, // 2
		'{SEG_H, SEG_R, SEG_R, SEG_R, SEG_R, SEG_H, SEG_R, SEG_R, SEG_R, SEG_R, SEG_H}, // 3
		'{SEG_O, SEG_B, SEG_B, SEG_B, SEG_B, SEG_H, SEG_R, SEG_R, SEG_R, SEG_R, SEG_O}, // 4
		'{SEG_H, SEG_L, SEG_L, SEG_L, SEG_L, SEG_H, SEG_R, SEG_R, SEG_R, SEG_R, SEG_H}, // 5
		'{SEG_H, SEG_L, SEG_L, SEG_L, SEG_L, SEG_H, SEG_B, SEG_B, SEG_B, SEG_B, SEG_H}, // 6
		'{SEG_H, SEG_R, SEG_R, SEG_R, SEG_R, SEG_O, SEG_R, SEG_R, SEG_R, SEG_R, SEG_O}, // 7
		'{SEG_H, SEG_B, SEG_B, SEG_B, SEG_B, SEG_H, SEG_B, SEG_B, SEG_B, SEG_B, SEG_H}, // 8
		'{SEG_H, SEG_B, SEG_B, SEG_B, SEG_B, SEG_H, SEG_R, SEG_R, SEG_R, SEG_R, SEG_O}  // 9, open tail
	};

	// "SCORE", five 10 px letters
	localparam glyph_row_t SCORE_ROWS [10] = '{
		50'b11111111001111111100111111110011111111001111111100,
		50'b11111111001111111100111111110011111111001111111100,
		50'b11000000001100000000110000110011000011001100000000,
		50'b11000000001100000000110000110011000011001100000000,
		50'b11111111001100000000110000110011111111001111111100,
		50'b11111111001100000000110000110011111111001111111100,
		50'b00000011001100000000110000110011110000001100000000,
		50'b00000011001100000000110000110011011000001100000000,
		50'b11111111001111111100111111110011001100001111111100,
		50'b11111111001111111100111111110011000011001111111100
	};

	// "TIMER", same cell pitch
	localparam glyph_row_t TIMER_ROWS [10] = '{
		50'b11111111001111111100111000111001111111100111111110,
		50'b11111111001111111100111101111001111111100111111110,
		50'b00011000000001100000110111011001100000000110000110,
		50'b00011000000001100000110010011001100000000110000110,
		50'b00011000000001100000110000011001111111100111111110,
		50'b00011000000001100000110000011001111111100111111110,
		50'b00011000000001100000110000011001100000000111100000,
		50'b00011000000001100000110000011001100000000110110000,
		50'b00011000001111111100110000011001111111100110011000,
		50'b00011000001111111100110000011001111111100110000110
	};

	// stage 2 to stage 3 payload
	typedef struct packed
	{
		screen_pkg::element_t element; // which box the pixel hit
		glyph_row_t row; // bitmap row, left aligned
		logic [5:0] col; // column inside the box
	} glyph_item_t;

endpackage

/* source/pixel_bus_if.sv */
`timescale 1ns/10ps

interface pixel_bus_if
#(
	parameter type payload_t = logic
);
	import screen_pkg::*;

	logic valid; // one pixel per cycle, no stall
	x_t x; // raster column
	y_t y; // raster row
	payload_t payload; // stage specific

	modport source
	(
		output valid,
		output x,
		output y,
		output payload
	);

	modport sink
	(
		input valid,
		input x,
		input y,
		input payload
	);

endinterface

/* source/pixel_compose.sv */
`timescale 1ns/10ps

module pixel_compose
(
	input logic iClock,
	input logic resetn,
	pixel_bus_if.sink glyph_bus,
	output screen_pkg::x_t x,
	output screen_pkg::y_t y,
	output glyph_pkg::colour_t colour,
	output logic plot
);
	import screen_pkg::*;
	import glyph_pkg::*;

	logic pix_on; // glyph bit at this column
	colour_t elem_colour; // colour of the hit element
	colour_t pix_colour; // final colour before output reg

	assign pix_on = glyph_bus.payload.row[GLYPH_ROW_W - 1 - int'(glyph_bus.payload.col)];

	always_comb
	begin
		case (glyph_bus.payload.element)
			EL_DIGIT0, EL_DIGIT1, EL_DIGIT2, EL_DIGIT3: elem_colour = DIGIT_COLOUR;
			EL_SCORE: elem_colour = SCORE_COLOUR;
			EL_TIMER: elem_colour = TIMER_COLOUR;
			default: elem_colour = BLACK;
		endcase
	end

	assign pix_colour = pix_on ? elem_colour : BLACK; // unlit bits are background

	always_ff @(posedge iClock)
	begin
		x <= glyph_bus.x;
		y <= glyph_bus.y;
		colour <= pix_colour;
	end

	always_ff @(posedge iClock)
	begin
		if (!resetn)
			plot <= 1'b0;
		else
			plot <= glyph_bus.valid; // two cycles behind scan valid
	end

	// the frame writer latches colour on every plot
	a_plot_colour_known: assert property (@(posedge iClock) disable iff (!resetn)
		plot |-> !$isunknown(colour));

endmodule

/* source/region_decode.sv */
`timescale 1ns/10ps

module region_decode
(
	input logic iClock,
	input logic resetn,
	input glyph_pkg::digit_t score_tens,
	input glyph_pkg::digit_t score_ones,
	input glyph_pkg::digit_t timer_tens,
	input glyph_pkg::digit_t timer_ones,
	pixel_bus_if.sink scan_bus,
	pixel_bus_if.source glyph_bus
);
	import screen_pkg::*;
	import glyph_pkg::*;

	// element boxes in priority order, index + 1 is the element code
	localparam int BOX_X [6] = '{DIGIT_X0, DIGIT_X1, DIGIT_X2, DIGIT_X3,
		SCORE_LBL_X, TIMER_LBL_X};
	localparam int BOX_Y [6] = '{DIGIT_Y, DIGIT_Y, DIGIT_Y, DIGIT_Y, LABEL_Y, LABEL_Y};
	localparam int BOX_W [6] = '{DIGIT_W, DIGIT_W, DIGIT_W, DIGIT_W, LABEL_W, LABEL_W};
	localparam int BOX_H [6] = '{DIGIT_H, DIGIT_H, DIGIT_H, DIGIT_H, LABEL_H, LABEL_H};

	digit_t [3:0] digit_q; // frame copy, [0] is score tens
	element_t element; // hit result
	logic [2:0] hit_idx; // box index of the hit
	x_t local_x; // column inside the box
	y_t local_y; // row inside the box
	digit_t cur_digit; // digit of the hit box
	logic [3:0] band; // 4-row band of a digit glyph
	glyph_row_t row; // looked-up bitmap row

	// freeze digits for the whole frame
	always_ff @(posedge iClock)
	begin
		if (!resetn)
			digit_q <= '0;
		else if (scan_bus.valid && scan_bus.payload)
			digit_q <= {timer_ones, timer_tens, score_ones, score_tens};
	end

	// fixed priority, lowest index wins, so walk from the top down
	always_comb
	begin
		element = EL_NONE;
		hit_idx = '0;
		for (int i = 5; i >= 0; i--)
		begin
			if ((int'(scan_bus.x) >= BOX_X[i]) && (int'(scan_bus.x) < BOX_X[i] + BOX_W[i]) &&
				(int'(scan_bus.y) >= BOX_Y[i]) && (int'(scan_bus.y) < BOX_Y[i] + BOX_H[i]))
			begin
				element = element_t'(i + 1);
				hit_idx = 3'(i);
			end
		end
	end

	always_comb
	begin
		if (element == EL_NONE)
		begin
			local_x = '0; // background needs no column
			local_y = '0;
		end
		else
		begin
			local_x = scan_bus.x - x_t'(BOX_X[hit_idx]);
			local_y = scan_bus.y - y_t'(BOX_Y[hit_idx]);
		end
	end

	assign cur_digit = digit_q[hit_idx[1:0]]; // only read for digit hits
	assign band = local_y[5:2]; // y / 4, at most 10 inside a digit box

	always_comb
	begin
		row = '0;
		case (element)
			EL_DIGIT0, EL_DIGIT1, EL_DIGIT2, EL_DIGIT3:
			begin
				if ((cur_digit <= 4'd9) && (band <= 4'd10)) // 10..15 stay blank
					row = {DIGIT_ROWS[cur_digit][band], {(GLYPH_ROW_W - DIGIT_W){1'b0}}};
			end
			EL_SCORE: row = SCORE_ROWS[local_y[3:0]];
			EL_TIMER: row = TIMER_ROWS[local_y[3:0]];
			default: row = '0;
		endcase
	end

	always_ff @(posedge iClock)
	begin
		if (!resetn)
			glyph_bus.valid <= 1'b0;
		else
			glyph_bus.valid <= scan_bus.valid;
	end

	// payload follows valid, no reset needed
	always_ff @(posedge iClock)
	begin
		glyph_bus.x <= scan_bus.x;
		glyph_bus.y <= scan_bus.y;
		glyph_bus.payload <= '{element: element, row: row, col: local_x[5:0]};
	end

	// frame copy is read by every digit pixel, must stay known
	a_digits_known: assert property (@(posedge iClock) disable iff (!resetn)
		!$isunknown(digit_q));

endmodule

/* source/scan_timing.sv */
`timescale 1ns/10ps

module scan_timing
#(
	parameter int FRAME_PERIOD = 2_500_000
)
(
	input logic iClock,
	input logic resetn,
	pixel_bus_if.source scan_bus
);
	import screen_pkg::*;

	localparam int CNT_W = $clog2(FRAME_PERIOD); // period counter width

	logic [CNT_W-1:0] period_cnt; // position inside refresh period
	logic in_window; // first 19200 cycles of the period
	x_t x_cnt;
	y_t y_cnt;
	logic x_last; // end of raster line
	logic y_last; // last raster line

	assign in_window = (int'(period_cnt) < PIXELS_PER_FRAME);
	assign x_last = (x_cnt == x_t'(SCREEN_W - 1));
	assign y_last = (y_cnt == y_t'(SCREEN_H - 1));

	always_ff @(posedge iClock)
	begin
		if (!resetn)
			period_cnt <= '0;
		else if (period_cnt == CNT_W'(FRAME_PERIOD - 1))
			period_cnt <= '0; // next refresh period
		else
			period_cnt <= period_cnt + 1'b1;
	end

	// raster walk, only while plotting
	always_ff @(posedge iClock)
	begin
		if (!resetn)
		begin
			x_cnt <= '0;
			y_cnt <= '0;
		end
		else if (in_window)
		begin
			if (x_last)
			begin
				x_cnt <= '0;
				y_cnt <= y_last ? '0 : y_cnt + 1'b1; // wraps after pixel 19199
			end
			else
				x_cnt <= x_cnt + 1'b1;
		end
	end

	assign scan_bus.valid = in_window;
	assign scan_bus.x = x_cnt;
	assign scan_bus.y = y_cnt;
	assign scan_bus.payload = in_window && (x_cnt == '0) && (y_cnt == '0); // frame_start

	// counters must never leave the frame, else the writer plots off-screen
	a_raster_in_frame: assert property (@(posedge iClock) disable iff (!resetn)
		(x_cnt < x_t'(SCREEN_W)) && (y_cnt < y_t'(SCREEN_H)));

endmodule

/* source/scoreboard_renderer.sv */
`timescale 1ns/10ps

module scoreboard_renderer
#(
	parameter int FRAME_PERIOD = 2_500_000
)
(
	input logic iClock,
	input logic resetn,
	input glyph_pkg::digit_t score_tens,
	input glyph_pkg::digit_t score_ones,
	input glyph_pkg::digit_t timer_tens,
	input glyph_pkg::digit_t timer_ones,
	output screen_pkg::x_t x,
	output screen_pkg::y_t y,
	output glyph_pkg::colour_t colour,
	output logic plot
);
	import glyph_pkg::*;

	pixel_bus_if #(.payload_t(logic)) scan_bus (); // frame_start flag
	pixel_bus_if #(.payload_t(glyph_item_t)) glyph_bus (); // element, row, column

	// stage 1, raster scan
	scan_timing #(.FRAME_PERIOD(FRAME_PERIOD)) u_scan
	(
		.iClock(iClock),
		.resetn(resetn),
		.scan_bus(scan_bus.source)
	);

	// stage 2, hit test and bitmap row
	region_decode u_decode
	(
		.iClock(iClock),
		.resetn(resetn),
		.score_tens(score_tens),
		.score_ones(score_ones),
		.timer_tens(timer_tens),
		.timer_ones(timer_ones),
		.scan_bus(scan_bus.sink),
		.glyph_bus(glyph_bus.source)
	);

	// stage 3, colour and output regs
	pixel_compose u_compose
	(
		.iClock(iClock),
		.resetn(resetn),
		.glyph_bus(glyph_bus.sink),
		.x(x),
		.y(y),
		.colour(colour),
		.plot(plot)
	);

endmodule

/* source/screen_pkg.sv */
package screen_pkg;

	localparam int SCREEN_W = 160; // frame store width
	localparam int SCREEN_H = 120; // frame store height
	localparam int PIXELS_PER_FRAME = SCREEN_W * SCREEN_H; // one plot per pixel

	typedef logic [7:0] x_t; // 0..159
	typedef logic [6:0] y_t; // 0..119

	localparam int DIGIT_W = 24; // seven-segment glyph box
	localparam int DIGIT_H = 44; // 11 bands of 4 rows
	localparam int LABEL_W = 50; // text label box
	localparam int LABEL_H = 10;

	// top-left corners, score pair on the left, timer pair on the right
	localparam int DIGIT_X0 = 10; // score tens
	localparam int DIGIT_X1 = 38; // score ones
	localparam int DIGIT_X2 = 98; // timer tens
	localparam int DIGIT_X3 = 126; // timer ones
	localparam int DIGIT_Y = 52; // shared by all four digits

	localparam int SCORE_LBL_X = 14; // under score pair
	localparam int TIMER_LBL_X = 102; // under timer pair
	localparam int LABEL_Y = 101; // both labels

	typedef enum logic [2:0]
	{
		EL_NONE, // background
		EL_DIGIT0,
		EL_DIGIT1,
		EL_DIGIT2,
		EL_DIGIT3,
		EL_SCORE,
		EL_TIMER
	} element_t;

endpackage

/* tb.f */
+incdir+sim
source/screen_pkg.sv
source/glyph_pkg.sv
source/pixel_bus_if.sv
source/scan_timing.sv
source/region_decode.sv
source/pixel_compose.sv
source/scoreboard_renderer.sv
sim/tb_scoreboard.sv
